// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_i2c_write_master
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/i2c_bus_sva.sv
`timescale 1ns/10ps

module i2c_bus_sva (
    input logic              clk,
    input logic              reset,
    input logic              scl_oe,
    input logic              sda_oe,
    input logic              sda_in,
    input logic              ack,
    input i2c_pkg::bit_cmd_e cmd
);
    import i2c_pkg::*;

    logic scl;

    assign scl = !scl_oe;

    // sda only moves with scl high for START and STOP
    property sda_stable_scl_high;
        @(posedge clk) disable iff (!reset)
        (scl && $past(scl) && (sda_in != $past(sda_in))) |-> (cmd == START || cmd == STOP);
    endproperty

    // Wishbone ack is a single cycle strobe
    property ack_one_cycle;
        @(posedge clk) disable iff (!reset)
        ack |=> !ack;
    endproperty

    property pads_released_in_reset;
        @(posedge clk)
        !reset |=> (!scl_oe && !sda_oe);
    endproperty

    assert property (sda_stable_scl_high)
    else $error("sda changed while scl high outside a start or stop");

    assert property (ack_one_cycle)
    else $error("wishbone ack held high for two cycles");

    assert property (pads_released_in_reset)
    else $error("scl or sda driven low after reset");

endmodule

bind i2c_write_master i2c_bus_sva i_bus_sva (
    .clk    (clk),
    .reset  (reset),
    .scl_oe (scl_oe),
    .sda_oe (sda_oe),
    .sda_in (sda_in),
    .ack    (wb_out.ack),
    .cmd    (cmd)
);

// File: bench/tb_i2c_write_master.sv
`timescale 1ns/10ps

module tb_i2c_write_master;
    import wb_pkg::*;
    import i2c_pkg::*;

    localparam int CMD_DEPTH   = 8;
    localparam int DATA_DEPTH  = 16;
    localparam int QUARTER_DIV = 4;
    localparam int ACK_LIMIT   = 8;
    localparam int EV_START    = 256;
    localparam int EV_STOP     = 512;
    localparam logic [6:0] NACK_ADDR = 7'h13;
    // bits per entry are START + 9 per byte incl. address + STOP
    // run 1: 47, run 2: 47 + 38 + 20, run 3: 47 + 11
    localparam int TOTAL_BITS  = 210;
    localparam int CYCLE_LIMIT = TOTAL_BITS * 4 * QUARTER_DIV + 3000;

    logic       clk = 1'b0;
    logic       reset;
    wb_req_t    wb_in;
    wb_rsp_t    wb_out;
    logic       scl_oe;
    logic       sda_oe;
    logic       sda_in = 1'b1;

    logic [7:0] data_ref [DATA_DEPTH];
    cmd_entry_t cmd_ref  [CMD_DEPTH];
    int         exp_q[$];
    int         seen_q[$];
    int         stream_pos = 0;
    int         checks = 0;
    int         errors = 0;
    int         cycles;

    // slave model state
    bit         scl;
    bit         sda;
    bit         scl_prev;
    bit         sda_prev;
    bit         slave_pull;
    bit         in_frame;
    bit         first_byte;
    bit         addr_ok;
    bit [7:0]   shreg;
    int         bit_cnt;

    i2c_write_master #(
        .CMD_DEPTH   (CMD_DEPTH),
        .DATA_DEPTH  (DATA_DEPTH),
        .QUARTER_DIV (QUARTER_DIV)
    ) i_dut (
        .clk    (clk),
        .reset  (reset),
        .wb_in  (wb_in),
        .wb_out (wb_out),
        .scl_oe (scl_oe),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic expect_eq(input int got, input int exp, input string what);
        checks++;
        assert (got == exp)
        else report_error($sformatf("%s: got %0h, expected %0h", what, got, exp));
    endtask

    task automatic wait_ack(output int waits);
        waits = 0;
        do begin
            @(posedge clk);
            #2;
            waits++;
        end while (!wb_out.ack && waits < ACK_LIMIT);
    endtask

    task automatic wb_write(input logic [6:0] adr, input logic [15:0] dat);
        int waits;
        @(posedge clk);
        #2;
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we  = 1'b1;
        wb_in.adr = adr;
        wb_in.dat = dat;
        wait_ack(waits);
        expect_eq(waits, 1, "write ack latency");
        wb_in = '0;
    endtask

    task automatic wb_read(input logic [6:0] adr, output logic [15:0] dat);
        int waits;
        @(posedge clk);
        #2;
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we  = 1'b0;
        wb_in.adr = adr;
        wb_in.dat = '0;
        wait_ack(waits);
        expect_eq(waits, 1, "read ack latency");
        dat = wb_out.dat;
        wb_in = '0;
    endtask

    task automatic write_entry(input int idx, input logic [6:0] addr,
                               input logic [3:0] first, input logic [3:0] last);
        cmd_ref[idx] = '{addr: addr, ptr_first: first, ptr_last: last};
        wb_write(REG_CMD_BASE + 7'(idx), {1'b0, addr, first, last});
    endtask

    // bus events the slave should decode for the first count entries
    task automatic queue_expected(input int count);
        for (int e = 0; e < count; e++) begin
            exp_q.push_back(EV_START);
            exp_q.push_back(int'({cmd_ref[e].addr, 1'b0}));
            if (cmd_ref[e].addr == NACK_ADDR) begin
                exp_q.push_back(EV_STOP);
                break;
            end
            for (int p = int'(cmd_ref[e].ptr_first); p <= int'(cmd_ref[e].ptr_last); p++) begin
                exp_q.push_back(int'(data_ref[p]));
            end
            exp_q.push_back(EV_STOP);
        end
    endtask

    task automatic check_stream();
        for (int i = stream_pos; i < exp_q.size(); i++) begin
            if (i < seen_q.size()) begin
                expect_eq(seen_q[i], exp_q[i], $sformatf("bus event %0d", i));
            end
        end
        expect_eq(seen_q.size(), exp_q.size(), "bus event count");
        stream_pos = exp_q.size();
    endtask

    task automatic run_table(input logic [3:0] count, input bit poke_busy, input bit exp_nack);
        logic [15:0] status;
        bit          saw_busy;
        saw_busy = 1'b0;
        queue_expected(int'(count));
        wb_write(REG_CTRL, {8'h00, count, 3'b000, 1'b1});
        if (poke_busy) begin
            // second start with another count, must be dropped
            wb_write(REG_CTRL, {8'h00, 4'd1, 3'b000, 1'b1});
        end
        do begin
            wb_read(REG_CTRL, status);
            saw_busy |= status[0];
        end while (status[0]);
        expect_eq(int'(saw_busy), 1, "busy during run");
        expect_eq(int'(status[1]), int'(exp_nack), "nack flag");
        expect_eq(int'(status[7:4]), int'(count), "entry count");
        check_stream();
    endtask

    // I2C slave, samples the bus just after each rising clock edge
    always @(posedge clk) begin
        #2;
        scl = !scl_oe;
        sda = !sda_oe && !slave_pull;
        if (!reset) begin
            slave_pull = 1'b0;
            in_frame   = 1'b0;
            bit_cnt    = 0;
        end else if (scl && scl_prev && sda_prev && !sda) begin
            seen_q.push_back(EV_START);
            in_frame   = 1'b1;
            first_byte = 1'b1;
            bit_cnt    = 0;
        end else if (scl && scl_prev && !sda_prev && sda) begin
            seen_q.push_back(EV_STOP);
            in_frame = 1'b0;
        end else if (in_frame && scl && !scl_prev) begin
            if (bit_cnt < 8) begin
                shreg = {shreg[6:0], sda};
            end
            bit_cnt++;
        end else if (in_frame && !scl && scl_prev) begin
            if (bit_cnt == 8) begin
                seen_q.push_back(int'(shreg));
                if (first_byte) begin
                    addr_ok = (shreg[7:1] != NACK_ADDR);
                end
                slave_pull = addr_ok;
            end else if (bit_cnt == 9) begin
                // ack clock done, let go of sda
                slave_pull = 1'b0;
                first_byte = 1'b0;
                bit_cnt    = 0;
            end
        end
        scl_prev = scl;
        sda_prev = sda;
        sda_in   = !sda_oe && !slave_pull;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation stopped: no result after %0d clock cycles", cycles);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [15:0] rd;
        logic [31:0] rnd;
        reset = 1'b0;
        wb_in = '0;
        rnd   = 32'h37e1b3c7;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b1;

        // idle status and released pads out of reset
        wb_read(REG_CTRL, rd);
        expect_eq(int'(rd), 0, "status after reset");
        expect_eq(int'({scl_oe, sda_oe}), 0, "pads after reset");

        for (int i = 0; i < DATA_DEPTH; i++) begin
            rnd = xorshift32(rnd);
            data_ref[i] = rnd[7:0];
            wb_write(REG_DATA_BASE + 7'(i), {8'h00, data_ref[i]});
        end
        write_entry(0, 7'h50, 4'd0, 4'd3);
        write_entry(1, 7'h21, 4'd4, 4'd6);
        write_entry(2, 7'h6a, 4'd7, 4'd7);

        for (int i = 0; i < DATA_DEPTH; i++) begin
            wb_read(REG_DATA_BASE + 7'(i), rd);
            expect_eq(int'(rd), int'(data_ref[i]), $sformatf("data word %0d", i));
        end
        for (int i = 0; i < 3; i++) begin
            wb_read(REG_CMD_BASE + 7'(i), rd);
            expect_eq(int'(rd), int'({1'b0, cmd_ref[i]}), $sformatf("table entry %0d", i));
        end

        run_table(4'd1, 1'b0, 1'b0);
        // three entries, with a start request while busy
        run_table(4'd3, 1'b1, 1'b0);
        // refused address in the middle aborts the rest
        write_entry(1, NACK_ADDR, 4'd8, 4'd9);
        run_table(4'd3, 1'b0, 1'b1);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
source/wb_pkg.sv
source/i2c_pkg.sv
source/wb_cmd_regs.sv
source/i2c_sequencer.sv
source/i2c_writer.sv
source/bit_xmit.sv
source/i2c_write_master.sv
bench/i2c_bus_sva.sv
bench/tb_i2c_write_master.sv

// File: source/bit_xmit.sv
`timescale 1ns/10ps

module bit_xmit #(
    parameter int QUARTER_DIV = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  i2c_pkg::bit_cmd_e cmd,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    output logic              done,
    output logic              ack_bit,
    output logic              scl_oe,
    output logic              sda_oe,
    input  logic              sda_in
);
    import i2c_pkg::*;

    localparam int QW = (QUARTER_DIV > 1) ? $clog2(QUARTER_DIV) : 1;

    bit_cmd_e      cmd_r;
    logic          active;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;
    logic          q_end;
    logic          scl_lvl;
    logic          sda_lvl;

    assign cmd_ready = !active;
    assign q_end     = (qcnt == QW'(QUARTER_DIV - 1));

    // bus levels per phase, 1 means released
    always_comb begin
        // data bits: scl high in the middle two quarters
        scl_lvl = phase[0] ^ phase[1];
        sda_lvl = 1'b1;
        case (cmd_r)
            START: begin
                // sda falls while scl is high, scl drops in the last quarter
                scl_lvl = (phase != 2'd3);
                sda_lvl = (phase == 2'd0);
            end
            STOP: begin
                // sda rises while scl is high, bus left idle
                scl_lvl = (phase != 2'd0);
                sda_lvl = phase[1];
            end
            SEND0: begin
                sda_lvl = 1'b0;
            end
            default: begin
                // SEND1 and RECV_ACK both release sda
                sda_lvl = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            active <= 1'b0;
            done   <= 1'b0;
            qcnt   <= '0;
            phase  <= 2'd0;
            scl_oe <= 1'b0;
            sda_oe <= 1'b0;
        end else begin
            done <= 1'b0;
            if (cmd_valid && cmd_ready) begin
                active <= 1'b1;
                qcnt   <= '0;
                phase  <= 2'd0;
            end else if (active) begin
                scl_oe <= !scl_lvl;
                sda_oe <= !sda_lvl;
                if (q_end) begin
                    qcnt  <= '0;
                    phase <= phase + 2'd1;
                    if (phase == 2'd3) begin
                        active <= 1'b0;
                        done   <= 1'b1;
                    end
                end else begin
                    qcnt <= qcnt + QW'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_r <= cmd;
        end
        // slave ack sampled at the end of the scl high window
        if (active && cmd_r == RECV_ACK && phase == 2'd2 && q_end) begin
            ack_bit <= sda_in;
        end
    end

endmodule

// File: source/i2c_pkg.sv
package i2c_pkg;

    // one write transaction: slave address plus an inclusive byte range
    typedef struct packed {
        logic [6:0] addr;
        logic [3:0] ptr_first;
        logic [3:0] ptr_last;
    } cmd_entry_t;

    // bit level opcodes handed to the bit transmitter
    typedef enum logic [2:0] {
        START    = 3'd0,
        STOP     = 3'd1,
        SEND0    = 3'd2,
        SEND1    = 3'd3,
        RECV_ACK = 3'd4
    } bit_cmd_e;

    // table sequencer
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        STAGE = 2'd1,
        WRITE = 2'd2,
        DONE  = 2'd3
    } seq_state_e;

    // byte level writer
    typedef enum logic [2:0] {
        WR_IDLE  = 3'd0,
        WR_START = 3'd1,
        WR_BIT   = 3'd2,
        WR_ACK   = 3'd3,
        WR_STOP  = 3'd4
    } wr_state_e;

endpackage

// File: source/i2c_sequencer.sv
`timescale 1ns/10ps

module i2c_sequencer #(
    parameter int CMD_DEPTH = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [3:0]          entry_count,
    output logic [3:0]          cmd_index,
    input  i2c_pkg::cmd_entry_t cmd_entry,
    output logic                init,
    output i2c_pkg::cmd_entry_t entry,
    input  logic                ready,
    input  logic                nack,
    output logic                run_done,
    output logic                run_nack
);
    import i2c_pkg::*;

    seq_state_e state;
    logic       last_entry;

    // table end is the written count or the table size, whichever is first
    assign last_entry = (cmd_index >= entry_count) || (cmd_index >= 4'(CMD_DEPTH));

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= IDLE;
            cmd_index <= 4'd0;
            init      <= 1'b0;
            run_done  <= 1'b0;
            run_nack  <= 1'b0;
        end else begin
            init     <= 1'b0;
            run_done <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    cmd_index <= 4'd0;
                    run_nack  <= 1'b0;
                    state     <= STAGE;
                end
                STAGE: if (last_entry) begin
                    state <= DONE;
                end else begin
                    init  <= 1'b1;
                    state <= WRITE;
                end
                WRITE: if (ready) begin
                    cmd_index <= cmd_index + 4'd1;
                    // a refused byte ends the whole run
                    if (nack) begin
                        run_nack <= 1'b1;
                        state    <= DONE;
                    end else begin
                        state <= STAGE;
                    end
                end
                DONE: begin
                    run_done <= 1'b1;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // entry is held stable for the writer during the whole transaction
    always_ff @(posedge clk) begin
        if (state == STAGE && !last_entry) begin
            entry <= cmd_entry;
        end
    end

endmodule

// File: source/i2c_write_master.sv
`timescale 1ns/10ps

module i2c_write_master #(
    parameter int CMD_DEPTH   = 8,
    parameter int DATA_DEPTH  = 16,
    parameter int QUARTER_DIV = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_req_t wb_in,
    output wb_pkg::wb_rsp_t wb_out,
    output logic            scl_oe,
    output logic            sda_oe,
    input  logic            sda_in
);
    import i2c_pkg::*;

    logic       start;
    logic [3:0] entry_count;
    logic [3:0] cmd_index;
    cmd_entry_t tbl_entry;
    logic [3:0] data_ptr;
    logic [7:0] data_byte;
    logic       run_done;
    logic       run_nack;

    cmd_entry_t entry;
    logic       init;
    logic       ready;
    logic       wr_nack;

    bit_cmd_e   cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       bit_done;
    logic       ack_bit;

    // host registers and both tables
    wb_cmd_regs #(
        .CMD_DEPTH  (CMD_DEPTH),
        .DATA_DEPTH (DATA_DEPTH)
    ) i_regs (
        .clk         (clk),
        .reset       (reset),
        .wb_in       (wb_in),
        .wb_out      (wb_out),
        .start       (start),
        .entry_count (entry_count),
        .cmd_index   (cmd_index),
        .cmd_entry   (tbl_entry),
        .data_ptr    (data_ptr),
        .data_byte   (data_byte),
        .run_done    (run_done),
        .nack        (run_nack)
    );

    i2c_sequencer #(
        .CMD_DEPTH (CMD_DEPTH)
    ) i_seq (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .entry_count (entry_count),
        .cmd_index   (cmd_index),
        .cmd_entry   (tbl_entry),
        .init        (init),
        .entry       (entry),
        .ready       (ready),
        .nack        (wr_nack),
        .run_done    (run_done),
        .run_nack    (run_nack)
    );

    // protocol level, one transaction per entry
    i2c_writer i_writer (
        .clk       (clk),
        .reset     (reset),
        .init      (init),
        .entry     (entry),
        .ready     (ready),
        .nack      (wr_nack),
        .data_ptr  (data_ptr),
        .data_byte (data_byte),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .done      (bit_done),
        .ack_bit   (ack_bit)
    );

    // signal level, drives the open drain enables
    bit_xmit #(
        .QUARTER_DIV (QUARTER_DIV)
    ) i_xmit (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .done      (bit_done),
        .ack_bit   (ack_bit),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

// File: source/i2c_writer.sv
`timescale 1ns/10ps

module i2c_writer (
    input  logic                clk,
    input  logic                reset,
    input  logic                init,
    input  i2c_pkg::cmd_entry_t entry,
    output logic                ready,
    output logic                nack,
    output logic [3:0]          data_ptr,
    input  logic [7:0]          data_byte,
    output i2c_pkg::bit_cmd_e   cmd,
    output logic                cmd_valid,
    input  logic                cmd_ready,
    input  logic                done,
    input  logic                ack_bit
);
    import i2c_pkg::*;

    wr_state_e  state;
    logic [7:0] shift;
    logic [2:0] bit_cnt;
    logic [3:0] last_ptr;
    logic       last_byte;

    function automatic bit_cmd_e send_op(input logic b);
        return b ? SEND1 : SEND0;
    endfunction

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= WR_IDLE;
            cmd_valid <= 1'b0;
            ready     <= 1'b0;
            nack      <= 1'b0;
        end else begin
            ready <= 1'b0;
            // hold off until the done strobe once the command is taken
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            case (state)
                WR_IDLE: if (init) begin
                    // address byte with R/W low for a write
                    shift      <= {entry.addr, 1'b0};
                    data_ptr   <= entry.ptr_first;
                    last_ptr   <= entry.ptr_last;
                    last_byte  <= 1'b0;
                    nack       <= 1'b0;
                    cmd        <= START;
                    cmd_valid  <= 1'b1;
                    state      <= WR_START;
                end
                WR_START: if (done) begin
                    bit_cnt   <= 3'd7;
                    cmd       <= send_op(shift[7]);
                    cmd_valid <= 1'b1;
                    state     <= WR_BIT;
                end
                WR_BIT: if (done) begin
                    if (bit_cnt == 3'd0) begin
                        cmd       <= RECV_ACK;
                        cmd_valid <= 1'b1;
                        state     <= WR_ACK;
                    end else begin
                        // msb first
                        shift     <= {shift[6:0], 1'b0};
                        bit_cnt   <= bit_cnt - 3'd1;
                        cmd       <= send_op(shift[6]);
                        cmd_valid <= 1'b1;
                    end
                end
                WR_ACK: if (done) begin
                    // last_byte stays low through the address byte
                    if (ack_bit || last_byte) begin
                        nack      <= ack_bit;
                        cmd       <= STOP;
                        cmd_valid <= 1'b1;
                        state     <= WR_STOP;
                    end else begin
                        // pointer runs one ahead so the next byte is ready at ack
                        shift      <= data_byte;
                        last_byte  <= (data_ptr == last_ptr);
                        data_ptr   <= data_ptr + 4'd1;
                        bit_cnt    <= 3'd7;
                        cmd        <= send_op(data_byte[7]);
                        cmd_valid  <= 1'b1;
                        state      <= WR_BIT;
                    end
                end
                WR_STOP: if (done) begin
                    ready <= 1'b1;
                    state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

endmodule

// File: source/wb_cmd_regs.sv
`timescale 1ns/10ps

module wb_cmd_regs #(
    parameter int CMD_DEPTH  = 8,
    parameter int DATA_DEPTH = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  wb_pkg::wb_req_t     wb_in,
    output wb_pkg::wb_rsp_t     wb_out,
    output logic                start,
    output logic [3:0]          entry_count,
    input  logic [3:0]          cmd_index,
    output i2c_pkg::cmd_entry_t cmd_entry,
    input  logic [3:0]          data_ptr,
    output logic [7:0]          data_byte,
    input  logic                run_done,
    input  logic                nack
);
    import wb_pkg::*;
    import i2c_pkg::*;

    localparam int CMD_W  = $clog2(CMD_DEPTH);
    localparam int DATA_W = $clog2(DATA_DEPTH);

    cmd_entry_t  cmd_mem  [CMD_DEPTH];
    logic [7:0]  data_mem [DATA_DEPTH];

    logic        req;
    logic        sel_ctrl;
    logic        sel_cmd;
    logic        sel_data;
    logic [6:0]  cmd_off;
    logic [6:0]  data_off;
    logic        ack_q;
    logic [15:0] rd_data;
    logic [15:0] rd_q;
    logic        busy;
    logic        nack_flag;

    // new request only when no ack is pending, so ack never repeats
    assign req = wb_in.cyc && wb_in.stb && !ack_q;

    // offsets wrap high below each base, one compare per window
    assign cmd_off  = wb_in.adr - REG_CMD_BASE;
    assign data_off = wb_in.adr - REG_DATA_BASE;
    assign sel_ctrl = (wb_in.adr == REG_CTRL);
    assign sel_cmd  = (cmd_off < 7'(CMD_DEPTH));
    assign sel_data = (data_off < 7'(DATA_DEPTH));

    always_comb begin
        rd_data = '0;
        if (sel_ctrl) begin
            rd_data = {8'h00, entry_count, 2'b00, nack_flag, busy};
        end else if (sel_cmd) begin
            rd_data = {1'b0, cmd_mem[cmd_off[CMD_W-1:0]]};
        end else if (sel_data) begin
            rd_data = {8'h00, data_mem[data_off[DATA_W-1:0]]};
        end
    end

    // table and data storage, plus the read data capture
    always_ff @(posedge clk) begin
        if (req && wb_in.we) begin
            if (sel_cmd) begin
                cmd_mem[cmd_off[CMD_W-1:0]] <= cmd_entry_t'(wb_in.dat[14:0]);
            end
            if (sel_data) begin
                data_mem[data_off[DATA_W-1:0]] <= wb_in.dat[7:0];
            end
        end
        if (req) begin
            rd_q <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            ack_q       <= 1'b0;
            start       <= 1'b0;
            busy        <= 1'b0;
            nack_flag   <= 1'b0;
            entry_count <= 4'd0;
        end else begin
            ack_q <= req;
            start <= 1'b0;
            // control writes are dropped while a run is in progress
            if (req && wb_in.we && sel_ctrl && !busy) begin
                entry_count <= wb_in.dat[7:4];
                if (wb_in.dat[0]) begin
                    start     <= 1'b1;
                    busy      <= 1'b1;
                    nack_flag <= 1'b0;
                end
            end
            if (run_done) begin
                busy      <= 1'b0;
                nack_flag <= nack;
            end
        end
    end

    assign wb_out.ack = ack_q;
    assign wb_out.dat = rd_q;

    // read ports for the sequencer and the writer
    assign cmd_entry = cmd_mem[cmd_index[CMD_W-1:0]];
    assign data_byte = data_mem[data_ptr[DATA_W-1:0]];

endmodule

// File: source/wb_pkg.sv
package wb_pkg;

    // one Wishbone classic request from the host
    // word addressed, 16-bit data
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [6:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    // slave reply, ack is a single-cycle strobe
    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    // control and status
    // wr: bit 0 start, bits 7..4 entry count
    // rd: bit 0 busy, bit 1 nack, bits 7..4 entry count
    localparam logic [6:0] REG_CTRL      = 7'd0;
    // command table, addr in 14..8, first ptr in 7..4, last ptr in 3..0
    localparam logic [6:0] REG_CMD_BASE  = 7'd16;
    // data memory, one byte per word in bits 7..0
    localparam logic [6:0] REG_DATA_BASE = 7'd64;

endpackage
